// ==== rvv_dispatch_pkg.sv ====
/* Shared types for the vector dispatch byte-type stage.
   Element widths, execution units, byte types and width helpers. */
package rvv_dispatch_pkg;

    localparam int UOP_INDEX_WIDTH = 3;

    typedef enum logic [2:0] {
        EEW_NONE = 3'd0,
        EEW1     = 3'd1,
        EEW8     = 3'd2,
        EEW16    = 3'd3,
        EEW32    = 3'd4
    } eew_e;

    typedef enum logic [1:0] {
        ALU = 2'd0,
        MUL = 2'd1,
        RDT = 2'd2,
        LSU = 2'd3
    } exe_unit_e;

    typedef enum logic [1:0] {
        NOT_CHANGE    = 2'd0,
        BODY_ACTIVE   = 2'd1,
        BODY_INACTIVE = 2'd2,
        TAIL          = 2'd3
    } byte_type_e;

    // bytes per vector register
    function automatic int f_vlenb(int vlen);
        return vlen / 8;
    endfunction

    // vl counts up to VLEN elements, so one extra bit
    function automatic int f_vl_width(int vlen);
        return $clog2(vlen) + 1;
    endfunction

    function automatic int f_vstart_width(int vlen);
        return $clog2(vlen);
    endfunction

    // log2 of element size in bytes
    function automatic logic [1:0] f_eew_shift(eew_e eew);
        case (eew)
            EEW16:   return 2'd1;
            EEW32:   return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

endpackage

// ==== rvv_v0_mask_reg.sv ====
/* v0 mask register.
   One write port, one combinational read port shared by both slots. */
module rvv_v0_mask_reg #(
    parameter int VLEN = 128
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            we,
    input  logic [VLEN-1:0] wdata,
    output logic [VLEN-1:0] rdata
);

    logic [VLEN-1:0] v0_q;

    // write lands at the edge, a same-cycle read sees the old mask
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v0_q <= '0;
        end else if (we) begin
            v0_q <= wdata;
        end
    end

    assign rdata = v0_q;

endmodule

// ==== rvv_v0_read_arbiter.sv ====
/* Round-robin arbiter for the shared v0 read port.
   Lone requester wins at once, conflicts go to the favoured slot. */
module rvv_v0_read_arbiter (
    input  logic clk,
    input  logic rst_n,
    input  logic req0,
    input  logic req1,
    output logic gnt0,
    output logic gnt1
);

    // 0 favours slot 0, 1 favours slot 1
    logic rr_ptr;

    assign gnt0 = req0 && (!req1 || !rr_ptr);
    assign gnt1 = req1 && (!req0 || rr_ptr);

    // after a grant, favour the slot that did not get it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= 1'b0;
        end else if (gnt0 || gnt1) begin
            rr_ptr <= gnt0;
        end
    end

endmodule

// ==== rvv_dispatch_opr_byte_type.sv ====
/* Byte-type generator for the vs2 and vd operands of one micro-op.
   Purely combinational, also produces the v0 write strobe per vd byte. */
module rvv_dispatch_opr_byte_type
    import rvv_dispatch_pkg::*;
#(
    parameter  int VLEN     = 128,
    localparam int VLENB    = f_vlenb(VLEN),
    localparam int VL_W     = f_vl_width(VLEN),
    localparam int VSTART_W = f_vstart_width(VLEN)
) (
    input  eew_e                          vs1_eew,
    input  eew_e                          vs2_eew,
    input  eew_e                          vd_eew,
    input  exe_unit_e                     exe_unit,
    input  logic [UOP_INDEX_WIDTH-1:0]    uop_index,
    input  logic                          vm,
    input  logic                          ignore_vta,
    input  logic                          ignore_vma,
    input  logic [VL_W-1:0]               vl,
    input  logic [VSTART_W-1:0]           vstart,
    input  logic [VLEN-1:0]               v0_enable,
    output byte_type_e [VLENB-1:0]        vs2_type,
    output byte_type_e [VLENB-1:0]        vd_type,
    output logic [VLENB-1:0]              v0_strobe
);

    localparam int VLENB_W = $clog2(VLENB);

    eew_e                eew_max;
    logic [1:0]          eew_max_shift;
    logic [1:0]          vs2_shift;
    logic [1:0]          vd_shift;
    logic [VSTART_W-1:0] vs2_start;
    logic [VSTART_W-1:0] vd_start;
    logic [VL_W-1:0]     vd_end;

    // widest operand sets the micro-op's element count
    always_comb begin
        if (vs1_eew == EEW32 || vs2_eew == EEW32 || vd_eew == EEW32) begin
            eew_max = EEW32;
        end else if (vs1_eew == EEW16 || vs2_eew == EEW16 || vd_eew == EEW16) begin
            eew_max = EEW16;
        end else if (vs1_eew == EEW8 || vs2_eew == EEW8 || vd_eew == EEW8) begin
            eew_max = EEW8;
        end else if (vs1_eew == EEW1 || vs2_eew == EEW1 || vd_eew == EEW1) begin
            eew_max = EEW1;
        end else begin
            eew_max = EEW_NONE;
        end
    end

    assign eew_max_shift = f_eew_shift(eew_max);
    assign vs2_shift     = f_eew_shift(vs2_eew);
    assign vd_shift      = f_eew_shift(vd_eew);

    // vs2 start element, widening drops low index bits
    always_comb begin
        if (exe_unit == RDT) begin
            vs2_start = VSTART_W'(uop_index) << (VLENB_W - vs2_shift);
        end else begin
            case ({eew_max, vs2_eew})
                {EEW32, EEW32}, {EEW16, EEW16}, {EEW8, EEW8}:
                    vs2_start = VSTART_W'(uop_index) << (VLENB_W - vs2_shift);
                {EEW32, EEW16}, {EEW16, EEW8}:
                    vs2_start = VSTART_W'(uop_index[UOP_INDEX_WIDTH-1:1])
                                << (VLENB_W - vs2_shift);
                {EEW32, EEW8}:
                    vs2_start = VSTART_W'(uop_index[UOP_INDEX_WIDTH-1:2])
                                << (VLENB_W - vs2_shift);
                default:
                    vs2_start = '0;
            endcase
        end
    end

    // vd start and end, narrowing fills vd over several micro-ops
    always_comb begin
        case ({eew_max, vd_eew})
            {EEW32, EEW32}, {EEW16, EEW16}, {EEW8, EEW8}: begin
                vd_start = VSTART_W'(uop_index) << (VLENB_W - vd_shift);
                vd_end   = VL_W'(vd_start) + VL_W'(VLENB >> eew_max_shift) - 1'b1;
            end
            {EEW32, EEW16}, {EEW16, EEW8}: begin
                vd_start = VSTART_W'(uop_index[UOP_INDEX_WIDTH-1:1]) << (VLENB_W - vd_shift);
                if (uop_index[0]) begin
                    vd_end = VL_W'(vd_start) + VL_W'(VLENB >> (eew_max_shift - 2'd1)) - 1'b1;
                end else begin
                    vd_end = VL_W'(vd_start) + VL_W'(VLENB >> eew_max_shift) - 1'b1;
                end
            end
            {EEW32, EEW8}: begin
                vd_start = VSTART_W'(uop_index[UOP_INDEX_WIDTH-1:2]) << VLENB_W;
                // a quarter of vd per index step
                vd_end   = VL_W'(vd_start) + VL_W'((uop_index[1:0] + 1) * VLENB / 4) - 1'b1;
            end
            default: begin
                vd_start = '0;
                vd_end   = '0;
            end
        endcase
    end

    for (genvar i = 0; i < VLENB; i++) begin : gen_byte
        logic [VL_W-1:0] vs2_ele;
        logic [VL_W-1:0] vd_ele;
        logic            vs2_en;
        logic            vd_en;

        assign vs2_ele = VL_W'(vs2_start) + VL_W'(i >> vs2_shift);
        assign vd_ele  = VL_W'(vd_start) + VL_W'(i >> vd_shift);
        assign vs2_en  = vm || v0_enable[vs2_ele[VSTART_W-1:0]];
        assign vd_en   = vm || v0_enable[vd_ele[VSTART_W-1:0]];

        always_comb begin
            if (ignore_vta && ignore_vma) begin
                vs2_type[i] = BODY_ACTIVE;
            end else if (vs2_ele >= vl) begin
                vs2_type[i] = TAIL;
            end else if (vs2_ele < VL_W'(vstart)) begin
                vs2_type[i] = NOT_CHANGE;
            end else begin
                vs2_type[i] = (vs2_en || ignore_vma) ? BODY_ACTIVE : BODY_INACTIVE;
            end
        end

        always_comb begin
            v0_strobe[i] = 1'b0;
            if (exe_unit == RDT) begin
                // scalar result sits in element 0 of vd
                case (vd_eew)
                    EEW32:   vd_type[i] = (i < 4) ? BODY_ACTIVE : TAIL;
                    EEW16:   vd_type[i] = (i < 2) ? BODY_ACTIVE : TAIL;
                    default: vd_type[i] = (i < 1) ? BODY_ACTIVE : TAIL;
                endcase
            end else if (ignore_vta && ignore_vma) begin
                vd_type[i] = BODY_ACTIVE;
            end else if (vd_ele >= vl) begin
                vd_type[i] = TAIL;
            end else if (vd_ele < VL_W'(vstart)) begin
                vd_type[i] = NOT_CHANGE;
            end else if (vd_ele > vd_end) begin
                vd_type[i] = BODY_INACTIVE;
            end else begin
                vd_type[i]   = (vd_en || ignore_vma) ? BODY_ACTIVE : BODY_INACTIVE;
                v0_strobe[i] = vd_en || ignore_vma;
            end
        end
    end

endmodule

// ==== rvv_dispatch_slot.sv ====
/* Dispatch slot for one micro-op per strobe.
   Requests v0 for masked micro-ops and registers the byte types. */
module rvv_dispatch_slot
    import rvv_dispatch_pkg::*;
#(
    parameter  int VLEN     = 128,
    localparam int VLENB    = f_vlenb(VLEN),
    localparam int VL_W     = f_vl_width(VLEN),
    localparam int VSTART_W = f_vstart_width(VLEN)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       uop_valid,
    input  eew_e                       vs1_eew,
    input  eew_e                       vs2_eew,
    input  eew_e                       vd_eew,
    input  exe_unit_e                  exe_unit,
    input  logic [UOP_INDEX_WIDTH-1:0] uop_index,
    input  logic                       vm,
    input  logic                       ignore_vta,
    input  logic                       ignore_vma,
    input  logic [VL_W-1:0]            vl,
    input  logic [VSTART_W-1:0]        vstart,
    output logic                       v0_req,
    input  logic                       v0_gnt,
    input  logic [VLEN-1:0]            v0_rdata,
    output logic                       busy,
    output logic                       out_valid,
    output byte_type_e [VLENB-1:0]     vs2_type,
    output byte_type_e [VLENB-1:0]     vd_type,
    output logic [VLENB-1:0]           v0_strobe
);

    typedef enum logic {
        IDLE,
        WAIT_V0
    } slot_state_e;

    typedef struct packed {
        eew_e                       vs1_eew;
        eew_e                       vs2_eew;
        eew_e                       vd_eew;
        exe_unit_e                  exe_unit;
        logic [UOP_INDEX_WIDTH-1:0] uop_index;
        logic                       vm;
        logic                       ignore_vta;
        logic                       ignore_vma;
        logic [VL_W-1:0]            vl;
        logic [VSTART_W-1:0]        vstart;
    } uop_t;

    slot_state_e            state;
    uop_t                   uop_in;
    uop_t                   uop_q;
    uop_t                   uop_cur;
    logic                   done;
    byte_type_e [VLENB-1:0] vs2_type_c;
    byte_type_e [VLENB-1:0] vd_type_c;
    logic [VLENB-1:0]       v0_strobe_c;

    assign uop_in = '{vs1_eew, vs2_eew, vd_eew, exe_unit, uop_index,
                      vm, ignore_vta, ignore_vma, vl, vstart};

    // live fields in the strobe cycle, held fields while waiting
    assign busy    = (state == WAIT_V0);
    assign uop_cur = busy ? uop_q : uop_in;

    // masked strobe asks for v0 right away so it sees the pre-write mask
    assign v0_req = busy || (uop_valid && !vm);
    assign done   = busy ? v0_gnt : (uop_valid && (vm || v0_gnt));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            out_valid <= 1'b0;
        end else begin
            out_valid <= done;
            case (state)
                IDLE:    if (uop_valid && !vm && !v0_gnt) state <= WAIT_V0;
                WAIT_V0: if (v0_gnt) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && uop_valid) begin
            uop_q <= uop_in;
        end
        if (done) begin
            vs2_type  <= vs2_type_c;
            vd_type   <= vd_type_c;
            v0_strobe <= v0_strobe_c;
        end
    end

    rvv_dispatch_opr_byte_type #(
        .VLEN(VLEN)
    ) u_byte_type (
        .vs1_eew    (uop_cur.vs1_eew),
        .vs2_eew    (uop_cur.vs2_eew),
        .vd_eew     (uop_cur.vd_eew),
        .exe_unit   (uop_cur.exe_unit),
        .uop_index  (uop_cur.uop_index),
        .vm         (uop_cur.vm),
        .ignore_vta (uop_cur.ignore_vta),
        .ignore_vma (uop_cur.ignore_vma),
        .vl         (uop_cur.vl),
        .vstart     (uop_cur.vstart),
        .v0_enable  (uop_cur.vm ? {VLEN{1'b1}} : v0_rdata),
        .vs2_type   (vs2_type_c),
        .vd_type    (vd_type_c),
        .v0_strobe  (v0_strobe_c)
    );

endmodule

// ==== rvv_dispatch_byte_type_top.sv ====
/* Operand byte-type stage with two dispatch slots.
   Both slots share the v0 read port through a round-robin arbiter. */
module rvv_dispatch_byte_type_top
    import rvv_dispatch_pkg::*;
#(
    parameter  int VLEN     = 128,
    localparam int VLENB    = f_vlenb(VLEN),
    localparam int VL_W     = f_vl_width(VLEN),
    localparam int VSTART_W = f_vstart_width(VLEN)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       v0_we,
    input  logic [VLEN-1:0]            v0_wdata,
    input  logic                       s0_uop_valid,
    input  eew_e                       s0_vs1_eew,
    input  eew_e                       s0_vs2_eew,
    input  eew_e                       s0_vd_eew,
    input  exe_unit_e                  s0_exe_unit,
    input  logic [UOP_INDEX_WIDTH-1:0] s0_uop_index,
    input  logic                       s0_vm,
    input  logic                       s0_ignore_vta,
    input  logic                       s0_ignore_vma,
    input  logic [VL_W-1:0]            s0_vl,
    input  logic [VSTART_W-1:0]        s0_vstart,
    output logic                       s0_busy,
    output logic                       s0_out_valid,
    output byte_type_e [VLENB-1:0]     s0_vs2_type,
    output byte_type_e [VLENB-1:0]     s0_vd_type,
    output logic [VLENB-1:0]           s0_v0_strobe,
    input  logic                       s1_uop_valid,
    input  eew_e                       s1_vs1_eew,
    input  eew_e                       s1_vs2_eew,
    input  eew_e                       s1_vd_eew,
    input  exe_unit_e                  s1_exe_unit,
    input  logic [UOP_INDEX_WIDTH-1:0] s1_uop_index,
    input  logic                       s1_vm,
    input  logic                       s1_ignore_vta,
    input  logic                       s1_ignore_vma,
    input  logic [VL_W-1:0]            s1_vl,
    input  logic [VSTART_W-1:0]        s1_vstart,
    output logic                       s1_busy,
    output logic                       s1_out_valid,
    output byte_type_e [VLENB-1:0]     s1_vs2_type,
    output byte_type_e [VLENB-1:0]     s1_vd_type,
    output logic [VLENB-1:0]           s1_v0_strobe
);

    logic            s0_v0_req;
    logic            s1_v0_req;
    logic            s0_v0_gnt;
    logic            s1_v0_gnt;
    logic [VLEN-1:0] v0_rdata;

    rvv_dispatch_slot #(.VLEN(VLEN)) u_slot0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .uop_valid  (s0_uop_valid),
        .vs1_eew    (s0_vs1_eew),
        .vs2_eew    (s0_vs2_eew),
        .vd_eew     (s0_vd_eew),
        .exe_unit   (s0_exe_unit),
        .uop_index  (s0_uop_index),
        .vm         (s0_vm),
        .ignore_vta (s0_ignore_vta),
        .ignore_vma (s0_ignore_vma),
        .vl         (s0_vl),
        .vstart     (s0_vstart),
        .v0_req     (s0_v0_req),
        .v0_gnt     (s0_v0_gnt),
        .v0_rdata   (v0_rdata),
        .busy       (s0_busy),
        .out_valid  (s0_out_valid),
        .vs2_type   (s0_vs2_type),
        .vd_type    (s0_vd_type),
        .v0_strobe  (s0_v0_strobe)
    );

    rvv_dispatch_slot #(.VLEN(VLEN)) u_slot1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .uop_valid  (s1_uop_valid),
        .vs1_eew    (s1_vs1_eew),
        .vs2_eew    (s1_vs2_eew),
        .vd_eew     (s1_vd_eew),
        .exe_unit   (s1_exe_unit),
        .uop_index  (s1_uop_index),
        .vm         (s1_vm),
        .ignore_vta (s1_ignore_vta),
        .ignore_vma (s1_ignore_vma),
        .vl         (s1_vl),
        .vstart     (s1_vstart),
        .v0_req     (s1_v0_req),
        .v0_gnt     (s1_v0_gnt),
        .v0_rdata   (v0_rdata),
        .busy       (s1_busy),
        .out_valid  (s1_out_valid),
        .vs2_type   (s1_vs2_type),
        .vd_type    (s1_vd_type),
        .v0_strobe  (s1_v0_strobe)
    );

    rvv_v0_read_arbiter u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req0  (s0_v0_req),
        .req1  (s1_v0_req),
        .gnt0  (s0_v0_gnt),
        .gnt1  (s1_v0_gnt)
    );

    rvv_v0_mask_reg #(.VLEN(VLEN)) u_v0_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (v0_we),
        .wdata (v0_wdata),
        .rdata (v0_rdata)
    );

endmodule

// ==== rvv_dispatch_byte_type_chk.sv ====
/* Assertions on v0 arbitration and slot timing, bound into the top level. */
module rvv_dispatch_byte_type_chk (
    input logic clk,
    input logic rst_n,
    input logic s0_v0_req,
    input logic s1_v0_req,
    input logic s0_v0_gnt,
    input logic s1_v0_gnt,
    input logic s0_uop_valid,
    input logic s1_uop_valid,
    input logic s0_vm,
    input logic s1_vm,
    input logic s0_busy,
    input logic s1_busy,
    input logic s0_out_valid,
    input logic s1_out_valid
);

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(s0_v0_gnt && s1_v0_gnt)) else $error("both v0 grants high");
    a_gnt0_req: assert property (@(posedge clk) disable iff (!rst_n)
        s0_v0_gnt |-> s0_v0_req) else $error("grant 0 without request");
    a_gnt1_req: assert property (@(posedge clk) disable iff (!rst_n)
        s1_v0_gnt |-> s1_v0_req) else $error("grant 1 without request");
    // unmasked micro-op finishes at the next edge
    a_s0_fast: assert property (@(posedge clk) disable iff (!rst_n)
        (s0_uop_valid && s0_vm && !s0_busy) |=> s0_out_valid) else $error("slot 0 late");
    a_s1_fast: assert property (@(posedge clk) disable iff (!rst_n)
        (s1_uop_valid && s1_vm && !s1_busy) |=> s1_out_valid) else $error("slot 1 late");
    a_s0_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (s0_busy ##1 s0_busy) |=> !s0_busy) else $error("slot 0 busy too long");
    a_s1_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (s1_busy ##1 s1_busy) |=> !s1_busy) else $error("slot 1 busy too long");

endmodule

bind rvv_dispatch_byte_type_top rvv_dispatch_byte_type_chk u_chk (.*);

// ==== rvv_dispatch_byte_type_tb.sv ====
/* Testbench for the two-slot operand byte-type stage.
   Table-driven stimulus checked against a reference model of the byte-type rules. */
module rvv_dispatch_byte_type_tb
    import rvv_dispatch_pkg::*;
;

    localparam int NTESTS = 14;
    localparam int PERIOD = 40;

    typedef struct packed {
        logic       fire;
        eew_e       vs1;
        eew_e       vs2;
        eew_e       vd;
        exe_unit_e  exe;
        logic [2:0] idx;
        logic       vm;
        logic       vta;
        logic       vma;
        logic [7:0] vl;
        logic [6:0] vstart;
    } uop_s;

    typedef struct packed {
        logic [127:0] v0;
        logic         collide;
        uop_s         u0;
        uop_s         u1;
    } entry_s;

    logic clk = 1'b0;
    logic rst_n;
    logic v0_we;
    logic [127:0] v0_wdata;
    uop_s drv0;
    uop_s drv1;
    logic valid0;
    logic valid1;
    logic s0_busy;
    logic s1_busy;
    logic s0_out_valid;
    logic s1_out_valid;
    logic [31:0] s0_vs2_type;
    logic [31:0] s0_vd_type;
    logic [15:0] s0_v0_strobe;
    logic [31:0] s1_vs2_type;
    logic [31:0] s1_vd_type;
    logic [15:0] s1_v0_strobe;

    entry_s tab [NTESTS];
    int     seed = 32'hfc61_a616;
    int     errors = 0;
    int     test_errs;

    always #(PERIOD / 2) clk = ~clk;

    rvv_dispatch_byte_type_top #(.VLEN(128)) u_dut (
        .clk(clk), .rst_n(rst_n), .v0_we(v0_we), .v0_wdata(v0_wdata),
        .s0_uop_valid(valid0), .s0_vs1_eew(drv0.vs1), .s0_vs2_eew(drv0.vs2),
        .s0_vd_eew(drv0.vd), .s0_exe_unit(drv0.exe), .s0_uop_index(drv0.idx),
        .s0_vm(drv0.vm), .s0_ignore_vta(drv0.vta), .s0_ignore_vma(drv0.vma),
        .s0_vl(drv0.vl), .s0_vstart(drv0.vstart), .s0_busy(s0_busy),
        .s0_out_valid(s0_out_valid), .s0_vs2_type(s0_vs2_type),
        .s0_vd_type(s0_vd_type), .s0_v0_strobe(s0_v0_strobe),
        .s1_uop_valid(valid1), .s1_vs1_eew(drv1.vs1), .s1_vs2_eew(drv1.vs2),
        .s1_vd_eew(drv1.vd), .s1_exe_unit(drv1.exe), .s1_uop_index(drv1.idx),
        .s1_vm(drv1.vm), .s1_ignore_vta(drv1.vta), .s1_ignore_vma(drv1.vma),
        .s1_vl(drv1.vl), .s1_vstart(drv1.vstart), .s1_busy(s1_busy),
        .s1_out_valid(s1_out_valid), .s1_vs2_type(s1_vs2_type),
        .s1_vd_type(s1_vd_type), .s1_v0_strobe(s1_v0_strobe)
    );

    function automatic uop_s mk(int fire, eew_e vs1, eew_e vs2, eew_e vd, exe_unit_e exe,
                                int idx, int vm, int vta, int vma, int vl, int vstart);
        uop_s u;
        u.fire   = 1'(fire);
        u.vs1    = vs1;
        u.vs2    = vs2;
        u.vd     = vd;
        u.exe    = exe;
        u.idx    = 3'(idx);
        u.vm     = 1'(vm);
        u.vta    = 1'(vta);
        u.vma    = 1'(vma);
        u.vl     = 8'(vl);
        u.vstart = 7'(vstart);
        return u;
    endfunction

    // log2 of bytes per element
    function automatic int shift_of(eew_e e);
        if (e == EEW32) return 2;
        if (e == EEW16) return 1;
        return 0;
    endfunction

    // tail, prestart, end bound, then mask
    function automatic logic [1:0] classify(uop_s u, int e, int end_e, logic [127:0] v0,
                                            output logic act);
        act = 1'b0;
        if (u.vta && u.vma) return BODY_ACTIVE;
        if (e >= int'(u.vl)) return TAIL;
        if (e < int'(u.vstart)) return NOT_CHANGE;
        if (e > end_e) return BODY_INACTIVE;
        act = u.vm || v0[e % 128] || u.vma;
        return act ? BODY_ACTIVE : BODY_INACTIVE;
    endfunction

    function automatic void model(uop_s u, logic [127:0] v0, output logic [31:0] vs2_t,
                                  output logic [31:0] vd_t, output logic [15:0] stb);
        int s2;
        int sd;
        int sm;
        int d2;
        int dd;
        int st2;
        int std;
        int end_e;
        logic act;
        s2 = shift_of(u.vs2);
        sd = shift_of(u.vd);
        sm = shift_of(u.vs1);
        if (s2 > sm) sm = s2;
        if (sd > sm) sm = sd;
        d2 = (u.exe == RDT) ? 0 : sm - s2;
        dd = sm - sd;
        st2 = (int'(u.idx) >> d2) << (4 - s2);
        std = (int'(u.idx) >> dd) << (4 - sd);
        // narrowing fills vd piece by piece
        end_e = std + ((int'(u.idx) & ((1 << dd) - 1)) + 1) * (16 >> sm) - 1;
        for (int i = 0; i < 16; i++) begin
            vs2_t[2*i +: 2] = classify(u, st2 + (i >> s2), 1 << 30, v0, act);
            if (u.exe == RDT) begin
                vd_t[2*i +: 2] = (i < (1 << sd)) ? BODY_ACTIVE : TAIL;
                stb[i] = 1'b0;
            end else begin
                vd_t[2*i +: 2] = classify(u, std + (i >> sd), end_e, v0, act);
                stb[i] = act;
            end
        end
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] got);
        if (exp !== got) begin
            $display("Error %s expected %h got %h", name, exp, got);
            test_errs++;
        end
    endtask

    task automatic load_table();
        logic [127:0] r;
        for (int t = 0; t < NTESTS; t++) begin
            r = {$random(seed), $random(seed), $random(seed), $random(seed)};
            tab[t].v0 = r;
            tab[t].collide = 1'b0;
            tab[t].u0 = mk(0, EEW8, EEW8, EEW8, ALU, 0, 1, 0, 0, 0, 0);
            tab[t].u1 = mk(0, EEW8, EEW8, EEW8, ALU, 0, 1, 0, 0, 0, 0);
        end
        tab[0].u0  = mk(1, EEW8, EEW8, EEW8, ALU, 0, 1, 0, 0, 10, 3);
        tab[0].u1  = mk(1, EEW16, EEW16, EEW16, ALU, 1, 1, 0, 0, 12, 2);
        tab[1].u0  = mk(1, EEW32, EEW32, EEW32, MUL, 2, 1, 0, 0, 10, 9);
        tab[2].u0  = mk(1, EEW8, EEW8, EEW8, ALU, 1, 0, 0, 0, 30, 0);
        tab[3].u1  = mk(1, EEW16, EEW16, EEW16, ALU, 0, 0, 0, 1, 7, 1);
        tab[4].u0  = mk(1, EEW8, EEW8, EEW16, ALU, 3, 1, 0, 0, 40, 0);
        tab[5].u1  = mk(1, EEW8, EEW8, EEW32, MUL, 5, 0, 0, 0, 60, 0);
        tab[6].u0  = mk(1, EEW8, EEW16, EEW8, ALU, 1, 1, 0, 0, 60, 2);
        tab[6].u1  = mk(1, EEW8, EEW16, EEW8, ALU, 0, 0, 0, 0, 20, 0);
        tab[7].u0  = mk(1, EEW8, EEW32, EEW8, ALU, 2, 0, 0, 0, 100, 0);
        tab[7].u1  = mk(1, EEW8, EEW32, EEW8, ALU, 3, 0, 0, 0, 60, 5);
        tab[8].u0  = mk(1, EEW8, EEW8, EEW8, RDT, 1, 1, 0, 0, 20, 0);
        tab[8].u1  = mk(1, EEW32, EEW32, EEW32, RDT, 0, 0, 0, 0, 3, 0);
        tab[9].u0  = mk(1, EEW16, EEW16, EEW16, RDT, 0, 1, 1, 1, 3, 0);
        tab[9].u1  = mk(1, EEW8, EEW8, EEW8, ALU, 0, 0, 1, 1, 3, 2);
        tab[10].u0 = mk(1, EEW8, EEW8, EEW8, ALU, 0, 0, 0, 0, 16, 0);
        tab[10].u1 = mk(1, EEW32, EEW32, EEW32, ALU, 1, 0, 0, 0, 8, 0);
        tab[11].u0 = mk(1, EEW16, EEW16, EEW16, LSU, 2, 0, 0, 0, 24, 17);
        tab[11].u1 = mk(1, EEW8, EEW8, EEW8, ALU, 3, 0, 0, 0, 64, 50);
        tab[12].u0 = mk(1, EEW8, EEW8, EEW8, ALU, 2, 0, 0, 0, 40, 0);
        tab[12].u1 = mk(1, EEW16, EEW16, EEW16, ALU, 0, 1, 0, 0, 5, 0);
        // write lands in the strobe cycle, result must use the old mask
        tab[13].collide = 1'b1;
        tab[13].u0 = mk(1, EEW8, EEW8, EEW8, ALU, 0, 0, 0, 0, 16, 0);
    endtask

    initial begin
        #((NTESTS * 10 + 5) * PERIOD);
        $display("watchdog timeout, the run did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] e_vs2 [2];
        logic [31:0] e_vd [2];
        logic [15:0] e_stb [2];
        logic done0;
        logic done1;
        int cyc;
        rst_n = 1'b0;
        v0_we = 1'b0;
        v0_wdata = '0;
        valid0 = 1'b0;
        valid1 = 1'b0;
        drv0 = '0;
        drv1 = '0;
        load_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int t = 0; t < NTESTS; t++) begin
            test_errs = 0;
            model(tab[t].u0, tab[t].v0, e_vs2[0], e_vd[0], e_stb[0]);
            model(tab[t].u1, tab[t].v0, e_vs2[1], e_vd[1], e_stb[1]);
            v0_we = 1'b1;
            v0_wdata = tab[t].v0;
            @(negedge clk);
            v0_we = tab[t].collide;
            v0_wdata = ~tab[t].v0;
            drv0 = tab[t].u0;
            drv1 = tab[t].u1;
            valid0 = tab[t].u0.fire;
            valid1 = tab[t].u1.fire;
            done0 = !tab[t].u0.fire;
            done1 = !tab[t].u1.fire;
            cyc = 0;
            while (!(done0 && done1) && cyc < 3) begin
                @(negedge clk);
                valid0 = 1'b0;
                valid1 = 1'b0;
                v0_we = 1'b0;
                cyc++;
                if (!done0 && s0_out_valid) begin
                    check("s0_vs2_type", e_vs2[0], s0_vs2_type);
                    check("s0_vd_type", e_vd[0], s0_vd_type);
                    check("s0_v0_strobe", 32'(e_stb[0]), 32'(s0_v0_strobe));
                    done0 = 1'b1;
                end
                if (!done1 && s1_out_valid) begin
                    check("s1_vs2_type", e_vs2[1], s1_vs2_type);
                    check("s1_vd_type", e_vd[1], s1_vd_type);
                    check("s1_v0_strobe", 32'(e_stb[1]), 32'(s1_v0_strobe));
                    done1 = 1'b1;
                end
                // a slot stays busy only while its micro-op waits for v0
                check("s0_busy", 32'(!done0), 32'(s0_busy));
                check("s1_busy", 32'(!done1), 32'(s1_busy));
            end
            if (!done0) begin
                $display("slot 0 gave no out_valid within 3 cycles");
                test_errs++;
            end
            if (!done1) begin
                $display("slot 1 gave no out_valid within 3 cycles");
                test_errs++;
            end
            $display("test %0d: %s", t, (test_errs == 0) ? "ok" : "mismatch");
            errors += test_errs;
        end
        $display("%0d tests, %0d errors", NTESTS, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== rvv_dispatch_byte_type_top.f ====
rvv_dispatch_pkg.sv
rvv_v0_mask_reg.sv
rvv_v0_read_arbiter.sv
rvv_dispatch_opr_byte_type.sv
rvv_dispatch_slot.sv
rvv_dispatch_byte_type_top.sv
rvv_dispatch_byte_type_chk.sv
rvv_dispatch_byte_type_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f rvv_dispatch_byte_type_top.f \
    --top-module rvv_dispatch_byte_type_tb -o sim_tb
out=$(./obj_dir/sim_tb || true)
echo "$out"
if echo "$out" | grep -q "=== PASS ==="; then
    exit 0
fi
exit 1
